//--- source/uart_consts.svh
// Shared constants for the word-wide UART subsystem.
// Include this header wherever a width, a depth or the oversample rate is needed.
// The package picks it up for its typedefs.

`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

`define UART_D_WIDTH     32  // Bus word width.
`define UART_I_DEPTH     4   // Input FIFO depth in words.
`define UART_O_DEPTH     4   // Output FIFO depth in words.
`define UART_OVERSAMPLE  16  // Ticks per bit.
`define UART_DIV_WIDTH   16

`endif

//--- source/uart_pkg.sv
// Types shared by the UART blocks.
// Refer to them with scoped names, for example uart_pkg::byte_t.

`include "uart_consts.svh"

package uart_pkg;

typedef logic [7:0]                 byte_t;
typedef logic [`UART_D_WIDTH-1:0]   word_t;
typedef logic [`UART_DIV_WIDTH-1:0] baud_div_t;  // Tick period minus one, in clock cycles.

// One-cycle error pulses.
typedef struct packed {
    logic frame_err;
    logic overrun;
} uart_status_t;

typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

endpackage

//--- source/width_fifo.sv
// Synchronous FIFO with different write and read widths.
// The wider side must be a power-of-two multiple of the narrower one.
// Entries are kept at the narrow width, little-endian within a wide beat.
// I_DEPTH counts write-side beats. Empty and full are registered, so a
// write shows up on the read side one cycle later.

`timescale 1ns/1ns

module width_fifo #(
    parameter int I_WIDTH = 32,
    parameter int I_DEPTH = 4,
    parameter int O_WIDTH = 8
) (
    input  logic               clk_i,
    input  logic               rst_n_i,

    input  logic               wr_valid_i,
    input  logic [I_WIDTH-1:0] wr_data_i,
    output logic               wr_ready_o,

    output logic               rd_valid_o,
    output logic [O_WIDTH-1:0] rd_data_o,
    input  logic               rd_ready_i
);

localparam int N     = (I_WIDTH < O_WIDTH) ? I_WIDTH : O_WIDTH;
localparam int WR_N  = I_WIDTH / N;  // Entries written per beat.
localparam int RD_N  = O_WIDTH / N;  // Entries read per beat.
localparam int DEPTH = I_DEPTH * WR_N;
localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CW    = $clog2(DEPTH + 1);

logic [N-1:0]  mem [DEPTH];
logic [AW-1:0] wr_ptr_q;
logic [AW-1:0] rd_ptr_q;
logic [CW-1:0] count_q;
logic [CW-1:0] count_d;
logic          full_q;
logic          empty_q;
logic          wr_fire;
logic          rd_fire;

// Circular index. The offset never exceeds one lap.
function automatic logic [AW-1:0] wrap_idx(input logic [AW-1:0] base, input int offset);
    int idx;
    idx = int'(base) + offset;
    if (idx >= DEPTH) begin
        idx = idx - DEPTH;
    end
    return AW'(idx);
endfunction

assign wr_ready_o = ~full_q;
assign rd_valid_o = ~empty_q;
assign wr_fire    = wr_valid_i & wr_ready_o;
assign rd_fire    = rd_valid_o & rd_ready_i;

always_comb begin
    count_d = count_q;
    if (wr_fire) begin
        count_d = count_d + CW'(WR_N);
    end
    if (rd_fire) begin
        count_d = count_d - CW'(RD_N);
    end
end

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
        full_q   <= 1'b0;
        empty_q  <= 1'b1;
    end else begin
        if (wr_fire) begin
            wr_ptr_q <= wrap_idx(wr_ptr_q, WR_N);
        end
        if (rd_fire) begin
            rd_ptr_q <= wrap_idx(rd_ptr_q, RD_N);
        end
        count_q <= count_d;
        full_q  <= (int'(count_d) > DEPTH - WR_N);  // No room for a whole write beat.
        empty_q <= (int'(count_d) < RD_N);          // Not enough for a whole read beat.
    end
end

always_ff @(posedge clk_i) begin
    if (wr_fire) begin
        for (int k = 0; k < WR_N; k++) begin
            mem[wrap_idx(wr_ptr_q, k)] <= wr_data_i[k*N +: N];
        end
    end
end

always_comb begin
    for (int k = 0; k < RD_N; k++) begin
        rd_data_o[k*N +: N] = mem[wrap_idx(rd_ptr_q, k)];
    end
end

// The registered full flag must keep every accepted write inside the memory.
assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wr_fire |-> (int'(count_q) + WR_N <= DEPTH));

endmodule

//--- source/uart_tx.sv
// UART transmitter. One accepted byte goes out as a start bit,
// eight data bits LSB first and a stop bit, each lasting one
// oversample period of ticks. tx_ready_o is high only while idle.

`timescale 1ns/1ns

`include "uart_consts.svh"

module uart_tx (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                tick_i,

    input  uart_pkg::byte_t     tx_data_i,
    input  logic                tx_valid_i,
    output logic                tx_ready_o,

    output logic                tx_o
);

localparam int OS = `UART_OVERSAMPLE;
localparam int TW = $clog2(OS);
localparam logic [TW-1:0] LAST_TICK = TW'(OS - 1);

uart_pkg::tx_state_e state_q;
logic [TW-1:0]       tick_cnt_q;
logic [2:0]          bit_cnt_q;
uart_pkg::byte_t     shift_q;
logic                tx_q;

assign tx_ready_o = (state_q == uart_pkg::TX_IDLE);
assign tx_o       = tx_q;

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        state_q    <= uart_pkg::TX_IDLE;
        tick_cnt_q <= '0;
        bit_cnt_q  <= '0;
        tx_q       <= 1'b1;
    end else if (state_q == uart_pkg::TX_IDLE) begin
        if (tx_valid_i) begin
            state_q    <= uart_pkg::TX_START;  // Line drops on the next tick.
            tick_cnt_q <= '0;
            bit_cnt_q  <= '0;
        end
    end else if (tick_i) begin
        tick_cnt_q <= tick_cnt_q + 1'b1;
        case (state_q)
            uart_pkg::TX_START: tx_q <= 1'b0;
            uart_pkg::TX_DATA:  tx_q <= shift_q[0];
            default:            tx_q <= 1'b1;
        endcase
        if (tick_cnt_q == LAST_TICK) begin
            if (state_q == uart_pkg::TX_START) begin
                state_q <= uart_pkg::TX_DATA;
            end else if (state_q == uart_pkg::TX_DATA) begin
                bit_cnt_q <= bit_cnt_q + 1'b1;
                if (bit_cnt_q == 3'd7) begin
                    state_q <= uart_pkg::TX_STOP;
                end
            end else begin
                state_q <= uart_pkg::TX_IDLE;
            end
        end
    end
end

always_ff @(posedge clk_i) begin
    if (tx_valid_i && tx_ready_o) begin
        shift_q <= tx_data_i;
    end else if (tick_i && state_q == uart_pkg::TX_DATA && tick_cnt_q == LAST_TICK) begin
        shift_q <= {1'b0, shift_q[7:1]};  // Next bit moves into position 0.
    end
end

// The line idles high between frames.
assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_q == uart_pkg::TX_IDLE) |-> tx_o);

endmodule

//--- source/uart_rx.sv
// UART receiver. The line is synchronized, a falling edge starts a frame
// and the start bit is confirmed at mid-bit, so a short glitch is ignored.
// Data bits are sampled at their middle and the stop bit is checked.
// rx_valid_o pulses for one cycle at the middle of the stop bit; a byte
// with a low stop bit still comes out, flagged by frame_err_o.

`timescale 1ns/1ns

`include "uart_consts.svh"

module uart_rx (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            tick_i,
    input  logic            rx_i,

    output uart_pkg::byte_t rx_data_o,
    output logic            rx_valid_o,
    output logic            frame_err_o
);

localparam int OS = `UART_OVERSAMPLE;
localparam int TW = $clog2(OS);
localparam logic [TW-1:0] LAST_TICK = TW'(OS - 1);
localparam logic [TW-1:0] HALF_TICK = TW'(OS / 2 - 1);

uart_pkg::rx_state_e state_q;
logic [TW-1:0]       tick_cnt_q;
logic [2:0]          bit_cnt_q;
uart_pkg::byte_t     shift_q;
logic                rx_meta_q;
logic                rx_sync_q;
logic                rx_prev_q;
logic                valid_q;
logic                ferr_q;

assign rx_data_o   = shift_q;
assign rx_valid_o  = valid_q;
assign frame_err_o = ferr_q;

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        rx_meta_q <= 1'b1;
        rx_sync_q <= 1'b1;
        rx_prev_q <= 1'b1;
    end else begin
        rx_meta_q <= rx_i;
        rx_sync_q <= rx_meta_q;
        rx_prev_q <= rx_sync_q;
    end
end

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        state_q    <= uart_pkg::RX_IDLE;
        tick_cnt_q <= '0;
        bit_cnt_q  <= '0;
        valid_q    <= 1'b0;
        ferr_q     <= 1'b0;
    end else begin
        valid_q <= 1'b0;
        ferr_q  <= 1'b0;
        if (state_q == uart_pkg::RX_IDLE) begin
            if (rx_prev_q && !rx_sync_q) begin
                state_q    <= uart_pkg::RX_START;
                tick_cnt_q <= '0;
                bit_cnt_q  <= '0;
            end
        end else if (tick_i) begin
            tick_cnt_q <= tick_cnt_q + 1'b1;
            case (state_q)
                uart_pkg::RX_START: begin
                    if (tick_cnt_q == HALF_TICK) begin
                        tick_cnt_q <= '0;  // Later bits are counted from mid-bit.
                        state_q    <= rx_sync_q ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (tick_cnt_q == LAST_TICK) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == 3'd7) begin
                            state_q <= uart_pkg::RX_STOP;
                        end
                    end
                end
                default: begin
                    if (tick_cnt_q == LAST_TICK) begin
                        valid_q <= 1'b1;
                        ferr_q  <= ~rx_sync_q;
                        state_q <= uart_pkg::RX_IDLE;
                    end
                end
            endcase
        end
    end
end

always_ff @(posedge clk_i) begin
    if (tick_i && state_q == uart_pkg::RX_DATA && tick_cnt_q == LAST_TICK) begin
        shift_q <= {rx_sync_q, shift_q[7:1]};  // LSB arrives first.
    end
end

assert property (@(posedge clk_i) disable iff (!rst_n_i)
    frame_err_o |-> rx_valid_o);

endmodule

//--- source/uart_core.sv
// Byte-level UART control. Makes the oversample tick from the divider,
// hands input bytes to the transmitter and registers received bytes
// toward the output side. A byte that arrives while the output side is
// not ready is dropped and reported as an overrun.
// Error pulses come out on status_o.

`timescale 1ns/1ns

module uart_core (
    input  logic                   clk_i,
    input  logic                   rst_n_i,

    input  uart_pkg::baud_div_t    baud_div_i,

    input  uart_pkg::byte_t        in_data_i,
    input  logic                   in_valid_i,
    output logic                   in_ready_o,

    output uart_pkg::byte_t        out_data_o,
    output logic                   out_valid_o,
    input  logic                   out_ready_i,

    input  logic                   rx_i,
    output logic                   tx_o,

    output uart_pkg::uart_status_t status_o
);

uart_pkg::baud_div_t    div_cnt_q;
logic                   tick;
uart_pkg::byte_t        rx_data;
logic                   rx_valid;
logic                   frame_err;
uart_pkg::byte_t        out_data_q;
logic                   out_valid_q;
logic                   take;
logic                   drop;
uart_pkg::uart_status_t status_q;

// A run-time change to a smaller divider must not stall the counter.
assign tick = (div_cnt_q >= baud_div_i);

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        div_cnt_q <= '0;
    end else begin
        div_cnt_q <= tick ? '0 : div_cnt_q + 1'b1;
    end
end

assign take        = rx_valid & out_ready_i;
assign drop        = rx_valid & ~out_ready_i;
assign out_data_o  = out_data_q;
assign out_valid_o = out_valid_q;
assign status_o    = status_q;

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        out_valid_q <= 1'b0;
        status_q    <= '0;
    end else begin
        if (take) begin
            out_valid_q <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_q <= 1'b0;
        end
        status_q.frame_err <= frame_err;
        status_q.overrun   <= drop;
    end
end

always_ff @(posedge clk_i) begin
    if (take) begin
        out_data_q <= rx_data;
    end
end

uart_tx uart_tx_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .tick_i     (tick),
    .tx_data_i  (in_data_i),
    .tx_valid_i (in_valid_i),
    .tx_ready_o (in_ready_o),
    .tx_o       (tx_o)
);

uart_rx uart_rx_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .tick_i      (tick),
    .rx_i        (rx_i),
    .rx_data_o   (rx_data),
    .rx_valid_o  (rx_valid),
    .frame_err_o (frame_err)
);

// The FIFO only fills through our own writes, so a held byte never meets a drop.
assert property (@(posedge clk_i) disable iff (!rst_n_i)
    drop |-> !out_valid_o);

endmodule

//--- source/uart.sv
// UART subsystem top level with 32-bit streaming ports.
// Words from the input port are split into bytes, LSB byte first, and sent
// on tx_o. Bytes received on rx_i are packed back into words in the same
// order. The bit rate is set at run time by baud_div_i.
// status_o carries one-cycle error pulses.

`timescale 1ns/1ns

`include "uart_consts.svh"

module uart #(
    parameter int I_DEPTH = `UART_I_DEPTH,  // Words.
    parameter int O_DEPTH = `UART_O_DEPTH   // Words.
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,

    input  uart_pkg::baud_div_t    baud_div_i,

    input  uart_pkg::word_t        in_data_i,
    input  logic                   in_valid_i,
    output logic                   in_ready_o,

    output uart_pkg::word_t        out_data_o,
    output logic                   out_valid_o,
    input  logic                   out_ready_i,

    input  logic                   rx_i,
    output logic                   tx_o,

    output uart_pkg::uart_status_t status_o
);

localparam int B_WIDTH = $bits(uart_pkg::byte_t);
localparam int W_BYTES = `UART_D_WIDTH / B_WIDTH;

uart_pkg::byte_t in_byte;
logic            in_byte_valid;
logic            in_byte_ready;

uart_pkg::byte_t out_byte;
logic            out_byte_valid;
logic            out_byte_ready;

width_fifo #(
    .I_WIDTH (`UART_D_WIDTH),
    .I_DEPTH (I_DEPTH),
    .O_WIDTH (B_WIDTH)
) fifo_in_data (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .wr_valid_i (in_valid_i),
    .wr_data_i  (in_data_i),
    .wr_ready_o (in_ready_o),
    .rd_valid_o (in_byte_valid),
    .rd_data_o  (in_byte),
    .rd_ready_i (in_byte_ready)
);

// Depth is given in bytes on the narrow write side.
width_fifo #(
    .I_WIDTH (B_WIDTH),
    .I_DEPTH (O_DEPTH * W_BYTES),
    .O_WIDTH (`UART_D_WIDTH)
) fifo_out_data (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .wr_valid_i (out_byte_valid),
    .wr_data_i  (out_byte),
    .wr_ready_o (out_byte_ready),
    .rd_valid_o (out_valid_o),
    .rd_data_o  (out_data_o),
    .rd_ready_i (out_ready_i)
);

uart_core uart_core_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .baud_div_i  (baud_div_i),
    .in_data_i   (in_byte),
    .in_valid_i  (in_byte_valid),
    .in_ready_o  (in_byte_ready),
    .out_data_o  (out_byte),
    .out_valid_o (out_byte_valid),
    .out_ready_i (out_byte_ready),
    .rx_i        (rx_i),
    .tx_o        (tx_o),
    .status_o    (status_o)
);

endmodule

//--- test/uart_tb.sv
// Testbench for the UART subsystem.
// rx_i is looped back from tx_o, except in the frame tests, where a
// bit-banger in the testbench drives the line at the same bit period.
// Returned words are compared with a byte-level reference model.

`timescale 1ns/1ns

`include "uart_consts.svh"

module uart_tb;

localparam int W_BYTES    = `UART_D_WIDTH / 8;
localparam int HELD_MAX   = `UART_O_DEPTH * W_BYTES;  // Bytes the output FIFO can hold.
localparam int BIT_CYCLES = 2 * `UART_OVERSAMPLE;     // Two cycles per tick at baud_div_i 1.
localparam int WAIT_LIMIT = 4000;
localparam int WORD_LIMIT = 2000;

logic                   clk_i = 1'b0;
logic                   rst_n_i;
uart_pkg::baud_div_t    baud_div_i;
uart_pkg::word_t        in_data_i;
logic                   in_valid_i;
logic                   in_ready_o;
uart_pkg::word_t        out_data_o;
logic                   out_valid_o;
logic                   out_ready_i;
logic                   rx_i;
logic                   tx_o;
uart_pkg::uart_status_t status_o;

logic            use_bb;
logic            bb_line;
logic [31:0]     lfsr_q;
uart_pkg::byte_t exp_bytes[$];
bit              exp_keep[$];  // Cleared for a byte the DUT has to drop.
int              held_bytes    = 0;
int              drops_planned = 0;
int              exp_drops     = 0;
int              exp_ferr      = 0;
int              words_seen    = 0;
int              overruns_seen = 0;
int              ferrs_seen    = 0;
int              data_errs     = 0;
int              check_errs    = 0;
int              timeout_errs  = 0;

always #4 clk_i = ~clk_i;

assign rx_i = use_bb ? bb_line : tx_o;

uart uart_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .baud_div_i  (baud_div_i),
    .in_data_i   (in_data_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .out_data_o  (out_data_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .rx_i        (rx_i),
    .tx_o        (tx_o),
    .status_o    (status_o)
);

// Galois LFSR, stepped once for every bit taken.
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
        val    = {val[30:0], lfsr_q[0]};
        lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return val;
endfunction

// While the output is stalled, bytes beyond the FIFO capacity are lost.
function automatic void push_byte(input uart_pkg::byte_t b, input bit stalled);
    bit keep;
    keep = 1'b1;
    if (stalled && held_bytes >= HELD_MAX) begin
        keep = 1'b0;
        drops_planned++;
    end else if (stalled) begin
        held_bytes++;
    end
    exp_bytes.push_back(b);
    exp_keep.push_back(keep);
endfunction

function automatic void push_word(input uart_pkg::word_t w, input bit stalled);
    for (int k = 0; k < W_BYTES; k++) begin
        push_byte(w[k*8 +: 8], stalled);
    end
endfunction

function automatic int kept_pending();
    int n;
    n = 0;
    foreach (exp_keep[i]) begin
        n += exp_keep[i];
    end
    return n;
endfunction

// Rebuilds the next word from its bytes, LSB byte first.
// Dropped bytes around it are popped and counted.
function automatic uart_pkg::word_t expect_word();
    uart_pkg::word_t w;
    int k;
    w = '0;
    k = 0;
    while (k < W_BYTES && exp_bytes.size() > 0) begin
        if (exp_keep[0]) begin
            w[k*8 +: 8] = exp_bytes[0];
            k++;
        end else begin
            exp_drops++;
        end
        void'(exp_bytes.pop_front());
        void'(exp_keep.pop_front());
    end
    while (exp_keep.size() > 0 && !exp_keep[0]) begin
        exp_drops++;
        void'(exp_bytes.pop_front());
        void'(exp_keep.pop_front());
    end
    return w;
endfunction

always @(posedge clk_i) begin
    uart_pkg::word_t exp;
    if (rst_n_i && out_valid_o && out_ready_i) begin
        assert (kept_pending() >= W_BYTES) else begin
            check_errs++;
            $display("a word came out of the output port while none was expected");
        end
        if (kept_pending() >= W_BYTES) begin
            exp = expect_word();
            assert (out_data_o === exp) else begin
                data_errs++;
                $display("error: out_data_o = %h, expected %h", out_data_o, exp);
            end
        end
        words_seen++;
    end
end

always @(posedge clk_i) begin
    if (rst_n_i) begin
        overruns_seen += status_o.overrun;
        ferrs_seen    += status_o.frame_err;
    end
end

// Starts at a falling edge and leaves in_valid_i high for a following word.
task automatic write_word(input uart_pkg::word_t w, input bit stalled, output bit waited);
    int cycles;
    cycles     = 0;
    in_data_i  = w;
    in_valid_i = 1'b1;
    while (!in_ready_o && cycles < WAIT_LIMIT) begin
        @(negedge clk_i);
        cycles++;
    end
    waited = (cycles > 0);
    assert (in_ready_o) else begin
        timeout_errs++;
        $display("the input port stayed busy and never took a word");
    end
    if (in_ready_o) begin
        push_word(w, stalled);
    end
    @(negedge clk_i);
endtask

task automatic wait_words(input int target);
    int cycles;
    int limit;
    cycles = 0;
    limit  = WORD_LIMIT * (target - words_seen + 1);
    while (words_seen < target && cycles < limit) begin
        @(negedge clk_i);
        cycles++;
    end
    assert (words_seen >= target) else begin
        timeout_errs++;
        $display("timed out waiting for word %0d on the output port", target);
    end
endtask

task automatic wait_overruns(input int target);
    int cycles;
    int limit;
    cycles = 0;
    limit  = WORD_LIMIT * (target - overruns_seen + 1);
    while (overruns_seen < target && cycles < limit) begin
        @(negedge clk_i);
        cycles++;
    end
    assert (overruns_seen >= target) else begin
        timeout_errs++;
        $display("timed out waiting for overrun pulse %0d", target);
    end
endtask

// Waits until tx_o has stayed high for two bit periods.
task automatic wait_line_idle();
    int cycles;
    int high_run;
    cycles   = 0;
    high_run = 0;
    while (high_run < 2 * BIT_CYCLES && cycles < WAIT_LIMIT) begin
        @(negedge clk_i);
        high_run = tx_o ? high_run + 1 : 0;
        cycles++;
    end
    assert (high_run >= 2 * BIT_CYCLES) else begin
        timeout_errs++;
        $display("the transmit line never went idle");
    end
endtask

task automatic send_frame(input uart_pkg::byte_t b, input logic stop_bit);
    logic [9:0] frame;
    frame = {stop_bit, b, 1'b0};
    push_byte(b, 1'b0);  // Before the frame, since the word can complete in the stop bit.
    if (!stop_bit) begin
        exp_ferr++;
    end
    for (int i = 0; i < 10; i++) begin
        bb_line = frame[i];
        repeat (BIT_CYCLES) @(negedge clk_i);
    end
    bb_line = 1'b1;
    repeat (2 * BIT_CYCLES) @(negedge clk_i);
endtask

initial begin
    logic [31:0] r;
    bit          waited;
    bit          stall_seen;
    rst_n_i     = 1'b0;
    baud_div_i  = 16'd1;
    in_data_i   = '0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b1;
    use_bb      = 1'b0;
    bb_line     = 1'b1;
    lfsr_q      = 32'h1468;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    // Idle line.
    assert (in_ready_o === 1'b1) else begin
        data_errs++;
        $display("error: in_ready_o = %h, expected 1", in_ready_o);
    end
    assert (status_o === '0) else begin
        data_errs++;
        $display("error: status_o = %h, expected 0", status_o);
    end
    repeat (64) begin
        @(negedge clk_i);
        assert (tx_o === 1'b1) else begin
            data_errs++;
            $display("error: tx_o = %h, expected 1", tx_o);
        end
        assert (out_valid_o === 1'b0) else begin
            data_errs++;
            $display("error: out_valid_o = %h, expected 0", out_valid_o);
        end
    end

    // Loopback of twelve words.
    for (int i = 0; i < 12; i++) begin
        write_word(rand_bits(32), 1'b0, waited);
    end
    in_valid_i = 1'b0;
    wait_words(12);

    // Input back-pressure.
    stall_seen = 1'b0;
    for (int i = 0; i < 6; i++) begin
        write_word(rand_bits(32), 1'b0, waited);
        stall_seen |= waited;
    end
    in_valid_i = 1'b0;
    assert (stall_seen) else begin
        check_errs++;
        $display("in_ready_o never dropped during back-to-back writes");
    end
    wait_words(18);

    // Output back-pressure with five words sent into room for four.
    held_bytes  = 0;
    out_ready_i = 1'b0;
    for (int i = 0; i < 5; i++) begin
        write_word(rand_bits(32), 1'b1, waited);
    end
    in_valid_i = 1'b0;
    wait_overruns(drops_planned);
    out_ready_i = 1'b1;
    wait_words(22);
    assert (overruns_seen == exp_drops) else begin
        data_errs++;
        $display("error: overrun pulses = %h, expected %h", overruns_seen, exp_drops);
    end

    // Bit-banged frames. The second word has one low stop bit.
    wait_line_idle();
    use_bb = 1'b1;
    for (int i = 0; i < 4; i++) begin
        r = rand_bits(8);
        send_frame(r[7:0], 1'b1);
    end
    wait_words(23);
    for (int i = 0; i < 4; i++) begin
        r = rand_bits(8);
        send_frame(r[7:0], i != 2);
    end
    wait_words(24);
    assert (ferrs_seen == exp_ferr) else begin
        data_errs++;
        $display("error: frame_err pulses = %h, expected %h", ferrs_seen, exp_ferr);
    end
    assert (exp_bytes.size() == 0) else begin
        check_errs++;
        $display("%0d expected bytes never came back", exp_bytes.size());
    end

    $display("errors: data %0d, protocol %0d, timeout %0d", data_errs, check_errs, timeout_errs);
    if (data_errs + check_errs + timeout_errs == 0) begin
        $display("Finished with no errors");
    end else begin
        $display("Finished with errors");
    end
    $finish;
end

endmodule

//--- uart_link.f
+incdir+source
source/uart_pkg.sv
source/width_fifo.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_core.sv
source/uart.sv
test/uart_tb.sv

//--- Bender.yml
package:
  name: uart_link

export_include_dirs:
  - source

sources:
  - files:
      - source/uart_pkg.sv
      - source/width_fifo.sv
      - source/uart_tx.sv
      - source/uart_rx.sv
      - source/uart_core.sv
      - source/uart.sv
  - target: test
    files:
      - test/uart_tb.sv
